// ==== hdl/flight_pkg.sv ====
`default_nettype none

package flight_pkg;

	// Decoded stick value, 0 to 255
	typedef logic [7:0] rc_val_t;
	// IMU Euler angle
	typedef logic signed [15:0] angle_t;
	// Angular rate, measured or commanded
	typedef logic signed [15:0] rate_t;
	// Motor command, 0 to MOTOR_MAX
	typedef logic [7:0] motor_rate_t;

	// One control frame per IMU strobe
	typedef enum logic [1:0] {
		IDLE,
		ANGLE,
		RATE,
		MIX
	} seq_state_t;

	// Stick centre
	localparam int RC_MID = 128;
	// Shortest valid receiver pulse, also the ESC zero-throttle pulse
	localparam int RC_MIN_US = 1000;
	localparam int MOTOR_MAX = 250;
	// Arm stick threshold
	localparam int ARM_LEVEL = 192;
	// Axis command scaling ahead of the mixer
	localparam int MIX_SHIFT = 4;

	// Clamp a wide signed result into rate_t
	function automatic rate_t sat_rate(input logic signed [19:0] v);
		if (v > 32767)
			return 16'sh7fff;
		else if (v < -32768)
			return 16'sh8000;
		else
			return v[15:0];
	endfunction

endpackage

`default_nettype wire

// ==== hdl/flight_sequencer.sv ====
`default_nettype none

module flight_sequencer #(
	parameter int TICKS_PER_US = 38
) (
	input wire sys_clk,
	input wire resetn,
	input wire imu_valid,
	input wire flight_pkg::rc_val_t arm_val,
	output logic us_tick,
	output logic armed,
	output logic angle_start,
	input wire angle_done,
	output logic rate_start,
	input wire rate_done,
	output logic mix_load
);

	localparam int TW = $clog2(TICKS_PER_US + 1);

	logic [TW-1:0] tick_cnt;
	flight_pkg::seq_state_t state;

	// Microsecond tick, one cycle wide
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			tick_cnt <= '0;
			us_tick <= 1'b0;
		end else if (tick_cnt == TW'(TICKS_PER_US - 1)) begin
			tick_cnt <= '0;
			us_tick <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			us_tick <= 1'b0;
		end
	end

	// Frame sequencing, stage strobes are single cycle
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= flight_pkg::IDLE;
			armed <= 1'b0;
			angle_start <= 1'b0;
			rate_start <= 1'b0;
			mix_load <= 1'b0;
		end else begin
			angle_start <= 1'b0;
			rate_start <= 1'b0;
			mix_load <= 1'b0;
			case (state)
				flight_pkg::IDLE: begin
					// Strobes in other states are dropped
					if (imu_valid) begin
						state <= flight_pkg::ANGLE;
						angle_start <= 1'b1;
						// Arm level only moves between frames
						armed <= (arm_val > 8'(flight_pkg::ARM_LEVEL));
					end
				end
				flight_pkg::ANGLE: begin
					if (angle_done) begin
						state <= flight_pkg::RATE;
						rate_start <= 1'b1;
					end
				end
				flight_pkg::RATE: begin
					if (rate_done) begin
						state <= flight_pkg::MIX;
						mix_load <= 1'b1;
					end
				end
				// Mixer loads during this cycle
				default: state <= flight_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rc_pulse_decoder.sv ====
`default_nettype none

module rc_pulse_decoder (
	input wire sys_clk,
	input wire resetn,
	input wire us_tick,
	input wire pulse,
	output flight_pkg::rc_val_t stick
);

	logic sync_1;
	logic sync_2;
	logic pulse_d;
	logic fall;
	// Pulse width in microseconds, sticks at all ones
	logic [11:0] width_us;
	logic [11:0] over_min;

	assign fall = pulse_d & ~sync_2;
	assign over_min = width_us - 12'(flight_pkg::RC_MIN_US);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			pulse_d <= 1'b0;
			width_us <= '0;
			stick <= '0;
		end else begin
			// Two flop synchroniser, third flop for edge detect
			sync_1 <= pulse;
			sync_2 <= sync_1;
			pulse_d <= sync_2;
			if (fall) begin
				width_us <= '0;
				// Short pulse floors at zero
				if (width_us < 12'(flight_pkg::RC_MIN_US))
					stick <= '0;
				else if (over_min[11:2] > 10'd255)
					stick <= 8'd255;
				else
					stick <= over_min[9:2];
			end else if (sync_2 && us_tick && width_us != '1) begin
				width_us <= width_us + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/angle_controller.sv ====
`default_nettype none

module angle_controller (
	input wire sys_clk,
	input wire resetn,
	input wire start,
	input wire flight_pkg::rc_val_t roll_stick,
	input wire flight_pkg::rc_val_t pitch_stick,
	input wire flight_pkg::rc_val_t yaw_stick,
	input wire flight_pkg::angle_t roll_angle,
	input wire flight_pkg::angle_t pitch_angle,
	output flight_pkg::rate_t roll_target,
	output flight_pkg::rate_t pitch_target,
	output flight_pkg::rate_t yaw_target,
	output logic done
);

	// Stick offsets from centre, scaled by four
	logic signed [19:0] roll_set;
	logic signed [19:0] pitch_set;
	logic signed [19:0] yaw_set;
	// Angle errors
	logic signed [19:0] roll_err;
	logic signed [19:0] pitch_err;

	assign roll_set = ($signed({12'd0, roll_stick}) - 20'(flight_pkg::RC_MID)) <<< 2;
	assign pitch_set = ($signed({12'd0, pitch_stick}) - 20'(flight_pkg::RC_MID)) <<< 2;
	assign yaw_set = ($signed({12'd0, yaw_stick}) - 20'(flight_pkg::RC_MID)) <<< 2;

	assign roll_err = roll_set - 20'(roll_angle);
	assign pitch_err = pitch_set - 20'(pitch_angle);

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			done <= 1'b0;
		else
			done <= start;
	end

	// Half the angle error becomes the rate target, yaw goes straight through
	always_ff @(posedge sys_clk) begin
		if (start) begin
			roll_target <= flight_pkg::sat_rate(roll_err >>> 1);
			pitch_target <= flight_pkg::sat_rate(pitch_err >>> 1);
			yaw_target <= flight_pkg::sat_rate(yaw_set);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rate_controller.sv ====
`default_nettype none

module rate_controller (
	input wire sys_clk,
	input wire resetn,
	input wire start,
	input wire flight_pkg::rate_t roll_target,
	input wire flight_pkg::rate_t pitch_target,
	input wire flight_pkg::rate_t yaw_target,
	input wire flight_pkg::rate_t roll_gyro,
	input wire flight_pkg::rate_t pitch_gyro,
	input wire flight_pkg::rate_t yaw_gyro,
	output flight_pkg::rate_t roll_cmd,
	output flight_pkg::rate_t pitch_cmd,
	output flight_pkg::rate_t yaw_cmd,
	output logic done
);

	// 0 roll, 1 pitch, 2 yaw
	logic [1:0] axis;
	logic active;
	flight_pkg::rate_t sel_target;
	flight_pkg::rate_t sel_gyro;
	// Shared error times gain
	logic signed [19:0] gain_out;

	// Start kicks off roll, counter carries pitch and yaw
	assign active = start | (axis != 2'd0);

	always_comb begin
		case (axis)
			2'd0: begin
				sel_target = roll_target;
				sel_gyro = roll_gyro;
			end
			2'd1: begin
				sel_target = pitch_target;
				sel_gyro = pitch_gyro;
			end
			default: begin
				sel_target = yaw_target;
				sel_gyro = yaw_gyro;
			end
		endcase
	end

	// Proportional gain of two
	assign gain_out = (20'(sel_target) - 20'(sel_gyro)) <<< 1;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			axis <= 2'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (active) begin
				if (axis == 2'd2) begin
					axis <= 2'd0;
					done <= 1'b1;
				end else begin
					axis <= axis + 1'b1;
				end
			end
		end
	end

	// Write back to the current axis
	always_ff @(posedge sys_clk) begin
		if (active) begin
			case (axis)
				2'd0: roll_cmd <= flight_pkg::sat_rate(gain_out);
				2'd1: pitch_cmd <= flight_pkg::sat_rate(gain_out);
				default: yaw_cmd <= flight_pkg::sat_rate(gain_out);
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/motor_mixer.sv ====
`default_nettype none

module motor_mixer (
	input wire sys_clk,
	input wire resetn,
	input wire load,
	input wire armed,
	input wire flight_pkg::rc_val_t throttle,
	input wire flight_pkg::rate_t roll_cmd,
	input wire flight_pkg::rate_t pitch_cmd,
	input wire flight_pkg::rate_t yaw_cmd,
	output flight_pkg::motor_rate_t motor_1_rate,
	output flight_pkg::motor_rate_t motor_2_rate,
	output flight_pkg::motor_rate_t motor_3_rate,
	output flight_pkg::motor_rate_t motor_4_rate
);

	logic signed [15:0] t;
	logic signed [15:0] r;
	logic signed [15:0] p;
	logic signed [15:0] y;

	// Keep motor range between 0 and MOTOR_MAX
	function automatic flight_pkg::motor_rate_t clamp_rate(input logic signed [15:0] s);
		if (s < 0)
			return '0;
		else if (s > flight_pkg::MOTOR_MAX)
			return 8'(flight_pkg::MOTOR_MAX);
		else
			return s[7:0];
	endfunction

	assign t = $signed({8'd0, throttle});
	// Arithmetic shift keeps command sign
	assign r = roll_cmd >>> flight_pkg::MIX_SHIFT;
	assign p = pitch_cmd >>> flight_pkg::MIX_SHIFT;
	assign y = yaw_cmd >>> flight_pkg::MIX_SHIFT;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
		end else if (load) begin
			// Disarmed frames park all motors
			if (!armed) begin
				motor_1_rate <= '0;
				motor_2_rate <= '0;
				motor_3_rate <= '0;
				motor_4_rate <= '0;
			end else begin
				// Quad-X, diagonal pairs share yaw sign
				motor_1_rate <= clamp_rate(t + p + r - y);
				motor_2_rate <= clamp_rate(t + p - r + y);
				motor_3_rate <= clamp_rate(t - p - r - y);
				motor_4_rate <= clamp_rate(t - p + r + y);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/esc_pwm.sv ====
`default_nettype none

module esc_pwm #(
	parameter int PWM_PERIOD_US = 4000
) (
	input wire sys_clk,
	input wire resetn,
	input wire us_tick,
	input wire flight_pkg::motor_rate_t motor_1_rate,
	input wire flight_pkg::motor_rate_t motor_2_rate,
	input wire flight_pkg::motor_rate_t motor_3_rate,
	input wire flight_pkg::motor_rate_t motor_4_rate,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);

	logic [15:0] frame_cnt;
	logic frame_end;
	// Outputs stay low until the first full frame
	logic running;
	flight_pkg::motor_rate_t shadow [4];
	flight_pkg::motor_rate_t rate_in [4];
	logic [3:0] pwm_q;

	assign rate_in[0] = motor_1_rate;
	assign rate_in[1] = motor_2_rate;
	assign rate_in[2] = motor_3_rate;
	assign rate_in[3] = motor_4_rate;

	assign frame_end = us_tick && (frame_cnt == 16'(PWM_PERIOD_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_cnt <= '0;
			running <= 1'b0;
			pwm_q <= '0;
		end else begin
			if (frame_end) begin
				frame_cnt <= '0;
				running <= 1'b1;
			end else if (us_tick) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			// High for 1000 us plus 4 us per rate step
			for (int i = 0; i < 4; i++)
				pwm_q[i] <= running &&
					(frame_cnt < 16'(flight_pkg::RC_MIN_US) + {6'd0, shadow[i], 2'b00});
		end
	end

	// Shadow rates change only on frame boundaries
	always_ff @(posedge sys_clk) begin
		if (frame_end) begin
			for (int i = 0; i < 4; i++)
				shadow[i] <= rate_in[i];
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

`default_nettype wire

// ==== hdl/drone_ctrl.sv ====
`default_nettype none

module drone_ctrl #(
	parameter int TICKS_PER_US = 38,
	parameter int PWM_PERIOD_US = 4000
) (
	input wire sys_clk,
	input wire resetn,
	input wire throttle_pwm,
	input wire roll_pwm,
	input wire pitch_pwm,
	input wire yaw_pwm,
	input wire arm_pwm,
	input wire imu_valid,
	input wire flight_pkg::angle_t roll_angle,
	input wire flight_pkg::angle_t pitch_angle,
	input wire flight_pkg::rate_t roll_gyro,
	input wire flight_pkg::rate_t pitch_gyro,
	input wire flight_pkg::rate_t yaw_gyro,
	output wire motor_1_pwm,
	output wire motor_2_pwm,
	output wire motor_3_pwm,
	output wire motor_4_pwm,
	output wire frame_done,
	output wire armed
);

	wire us_tick;
	// Stage strobes
	wire angle_start;
	wire angle_done;
	wire rate_start;
	wire rate_done;
	wire mix_load;
	// Decoded sticks
	flight_pkg::rc_val_t throttle_val;
	flight_pkg::rc_val_t roll_val;
	flight_pkg::rc_val_t pitch_val;
	flight_pkg::rc_val_t yaw_val;
	flight_pkg::rc_val_t arm_val;
	// Rate targets and axis commands
	flight_pkg::rate_t roll_target;
	flight_pkg::rate_t pitch_target;
	flight_pkg::rate_t yaw_target;
	flight_pkg::rate_t roll_cmd;
	flight_pkg::rate_t pitch_cmd;
	flight_pkg::rate_t yaw_cmd;
	flight_pkg::motor_rate_t motor_1_rate;
	flight_pkg::motor_rate_t motor_2_rate;
	flight_pkg::motor_rate_t motor_3_rate;
	flight_pkg::motor_rate_t motor_4_rate;

	// Frame completes as the mixer loads
	assign frame_done = mix_load;

	flight_sequencer #(
		.TICKS_PER_US(TICKS_PER_US)
	) i_seq (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.imu_valid(imu_valid),
		.arm_val(arm_val),
		.us_tick(us_tick),
		.armed(armed),
		.angle_start(angle_start),
		.angle_done(angle_done),
		.rate_start(rate_start),
		.rate_done(rate_done),
		.mix_load(mix_load)
	);

	// Receiver channels
	rc_pulse_decoder i_rc_throttle (.sys_clk(sys_clk), .resetn(resetn),
		.us_tick(us_tick), .pulse(throttle_pwm), .stick(throttle_val));
	rc_pulse_decoder i_rc_roll (.sys_clk(sys_clk), .resetn(resetn),
		.us_tick(us_tick), .pulse(roll_pwm), .stick(roll_val));
	rc_pulse_decoder i_rc_pitch (.sys_clk(sys_clk), .resetn(resetn),
		.us_tick(us_tick), .pulse(pitch_pwm), .stick(pitch_val));
	rc_pulse_decoder i_rc_yaw (.sys_clk(sys_clk), .resetn(resetn),
		.us_tick(us_tick), .pulse(yaw_pwm), .stick(yaw_val));
	rc_pulse_decoder i_rc_arm (.sys_clk(sys_clk), .resetn(resetn),
		.us_tick(us_tick), .pulse(arm_pwm), .stick(arm_val));

	angle_controller i_angle (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.start(angle_start),
		.roll_stick(roll_val),
		.pitch_stick(pitch_val),
		.yaw_stick(yaw_val),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_target(yaw_target),
		.done(angle_done)
	);

	rate_controller i_rate (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.start(rate_start),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_target(yaw_target),
		.roll_gyro(roll_gyro),
		.pitch_gyro(pitch_gyro),
		.yaw_gyro(yaw_gyro),
		.roll_cmd(roll_cmd),
		.pitch_cmd(pitch_cmd),
		.yaw_cmd(yaw_cmd),
		.done(rate_done)
	);

	motor_mixer i_mixer (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.load(mix_load),
		.armed(armed),
		.throttle(throttle_val),
		.roll_cmd(roll_cmd),
		.pitch_cmd(pitch_cmd),
		.yaw_cmd(yaw_cmd),
		.motor_1_rate(motor_1_rate),
		.motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate),
		.motor_4_rate(motor_4_rate)
	);

	esc_pwm #(
		.PWM_PERIOD_US(PWM_PERIOD_US)
	) i_esc (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.motor_1_rate(motor_1_rate),
		.motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate),
		.motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
	output logic sys_clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES = 8;

	// 4 ns period
	initial begin
		sys_clk = 1'b0;
		forever #HALF_PERIOD_NS sys_clk = ~sys_clk;
	end

	// Low for eight cycles, released just after a rising edge
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1 resetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_drone_ctrl.sv ====
`default_nettype none

module tb_drone_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICKS_PER_US = 2;
	localparam int PWM_PERIOD_US = 2500;
	localparam int MAX_FRAMES = 64;
	localparam int NUM_COLS = 15;
	// Loop limits in sys_clk cycles
	localparam int RESET_TIMEOUT = 50;
	localparam int PULSE_TIMEOUT = 6000;
	localparam int FRAME_TIMEOUT = 20;
	localparam int ESC_TIMEOUT = 4 * PWM_PERIOD_US * TICKS_PER_US;
	// imu_valid to frame_done
	localparam int FRAME_LATENCY = 7;
	localparam int QUIET_CYCLES = 12;
	localparam int IDLE_CHECK_CYCLES = 50;
	// ESC pulse for rate 0, and the step per rate count
	localparam int ESC_MIN_US = 1000;
	localparam int ESC_STEP_US = 4;

	logic sys_clk;
	logic resetn;
	logic throttle_pwm;
	logic roll_pwm;
	logic pitch_pwm;
	logic yaw_pwm;
	logic arm_pwm;
	logic imu_valid;
	flight_pkg::angle_t roll_angle;
	flight_pkg::angle_t pitch_angle;
	flight_pkg::rate_t roll_gyro;
	flight_pkg::rate_t pitch_gyro;
	flight_pkg::rate_t yaw_gyro;
	logic motor_1_pwm;
	logic motor_2_pwm;
	logic motor_3_pwm;
	logic motor_4_pwm;
	logic frame_done;
	logic armed;

	// Pulse widths, IMU, armed, motor rates
	int vec [MAX_FRAMES][NUM_COLS];
	int num_frames;
	int errors;
	int checks;
	logic timed_out;
	// Context for error lines
	string phase_tag;

	tb_clock i_clock (
		.sys_clk(sys_clk),
		.resetn(resetn)
	);

	drone_ctrl #(
		.TICKS_PER_US(TICKS_PER_US),
		.PWM_PERIOD_US(PWM_PERIOD_US)
	) i_dut (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.yaw_pwm(yaw_pwm),
		.arm_pwm(arm_pwm),
		.imu_valid(imu_valid),
		.roll_angle(roll_angle),
		.pitch_angle(pitch_angle),
		.roll_gyro(roll_gyro),
		.pitch_gyro(pitch_gyro),
		.yaw_gyro(yaw_gyro),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm),
		.frame_done(frame_done),
		.armed(armed)
	);

	task automatic check_motor(input string name, input flight_pkg::motor_rate_t got,
			input flight_pkg::motor_rate_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %s (%s): got 0x%02h, expected 0x%02h", name, phase_tag, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %s (%s): got 0x%0h, expected 0x%0h", name, phase_tag, got, exp);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("Fail %s (%s): got 0x%0h, expected 0x%0h", name, phase_tag, got, exp);
			errors++;
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		int col [NUM_COLS];
		string line;
		fd = $fopen("testbench/flight_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file testbench/flight_vectors.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && num_frames < MAX_FRAMES) begin
			if ($fgets(line, fd) == 0)
				break;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
			// Comment and blank lines give no fields
			if (n == NUM_COLS) begin
				for (int k = 0; k < NUM_COLS; k++)
					vec[num_frames][k] = col[k];
				num_frames++;
			end else if (n > 0) begin
				$display("Vector line has %0d fields instead of %0d: %s", n, NUM_COLS, line);
				errors++;
			end
		end
		$fclose(fd);
		if (num_frames == 0) begin
			$display("The vector file holds no frames");
			errors++;
		end
	endtask

	task automatic wait_reset_release();
		int cyc;
		cyc = 0;
		// resetn is stable at the rising edge, unknown counts as still in reset
		while (resetn !== 1'b1 && cyc < RESET_TIMEOUT) begin
			@(posedge sys_clk);
			cyc++;
		end
		if (resetn !== 1'b1) begin
			$display("Timeout waiting for reset release");
			errors++;
			timed_out = 1'b1;
		end
		#1;
	endtask

	// Outputs quiet before any frame runs
	task automatic check_idle_after_reset();
		phase_tag = "after reset";
		for (int k = 0; k < IDLE_CHECK_CYCLES; k++) begin
			@(posedge sys_clk);
			#1;
			check_flag("motor_1_pwm", motor_1_pwm, 1'b0);
			check_flag("motor_2_pwm", motor_2_pwm, 1'b0);
			check_flag("motor_3_pwm", motor_3_pwm, 1'b0);
			check_flag("motor_4_pwm", motor_4_pwm, 1'b0);
			check_flag("armed", armed, 1'b0);
			check_flag("frame_done", frame_done, 1'b0);
		end
	endtask

	// All five channels rise together, each falls after its own width
	task automatic drive_sticks(input int f);
		int cyc;
		logic busy;
		cyc = 0;
		busy = 1'b1;
		while (busy && cyc < PULSE_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			throttle_pwm = (cyc < vec[f][0] * TICKS_PER_US);
			roll_pwm = (cyc < vec[f][1] * TICKS_PER_US);
			pitch_pwm = (cyc < vec[f][2] * TICKS_PER_US);
			yaw_pwm = (cyc < vec[f][3] * TICKS_PER_US);
			arm_pwm = (cyc < vec[f][4] * TICKS_PER_US);
			busy = throttle_pwm | roll_pwm | pitch_pwm | yaw_pwm | arm_pwm;
			cyc++;
		end
		if (busy) begin
			$display("Timeout driving receiver pulses in %s", phase_tag);
			errors++;
			timed_out = 1'b1;
			throttle_pwm = 1'b0;
			roll_pwm = 1'b0;
			pitch_pwm = 1'b0;
			yaw_pwm = 1'b0;
			arm_pwm = 1'b0;
		end
	endtask

	task automatic run_frame(input int f, input logic double_strobe);
		int cyc;
		logic seen;
		@(posedge sys_clk);
		#1;
		roll_angle = flight_pkg::angle_t'(vec[f][5]);
		pitch_angle = flight_pkg::angle_t'(vec[f][6]);
		roll_gyro = flight_pkg::rate_t'(vec[f][7]);
		pitch_gyro = flight_pkg::rate_t'(vec[f][8]);
		yaw_gyro = flight_pkg::rate_t'(vec[f][9]);
		imu_valid = 1'b1;
		cyc = 0;
		seen = 1'b0;
		while (!seen && cyc < FRAME_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			cyc++;
			// Second strobe lands while the rate stage runs
			imu_valid = double_strobe && (cyc == 3);
			seen = frame_done;
		end
		imu_valid = 1'b0;
		if (!seen) begin
			$display("Timeout waiting for frame_done in %s", phase_tag);
			errors++;
			timed_out = 1'b1;
			return;
		end
		check_latency("frame_done latency", cyc, FRAME_LATENCY);
		check_flag("armed", armed, vec[f][10] != 0);
		// A dropped strobe must not start another frame
		for (int k = 0; k < QUIET_CYCLES; k++) begin
			@(posedge sys_clk);
			#1;
			check_flag("frame_done", frame_done, 1'b0);
		end
	endtask

	// One full ESC pulse per motor, from the first rise seen after a low
	task automatic measure_motors(input int f);
		int phase [4];
		int width [4];
		int cyc;
		int hi_us;
		logic [3:0] pwm;
		logic all_done;
		for (int m = 0; m < 4; m++) begin
			phase[m] = 0;
			width[m] = 0;
		end
		cyc = 0;
		all_done = 1'b0;
		// Starts well after mix_load, so any rise comes from latched new rates
		while (!all_done && cyc < ESC_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			cyc++;
			pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
			all_done = 1'b1;
			for (int m = 0; m < 4; m++) begin
				case (phase[m])
					0: if (!pwm[m]) phase[m] = 1;
					1: begin
						if (pwm[m]) begin
							phase[m] = 2;
							width[m] = 1;
						end
					end
					2: begin
						if (pwm[m])
							width[m]++;
						else
							phase[m] = 3;
					end
					default: ;
				endcase
				if (phase[m] != 3)
					all_done = 1'b0;
			end
		end
		if (!all_done) begin
			$display("Timeout measuring ESC pulses in %s", phase_tag);
			errors++;
			timed_out = 1'b1;
			return;
		end
		for (int m = 0; m < 4; m++) begin
			hi_us = width[m] / TICKS_PER_US;
			if (hi_us < ESC_MIN_US || hi_us > ESC_MIN_US + 255 * ESC_STEP_US) begin
				$display("ESC pulse on motor %0d is %0d us long, out of range in %s",
					m + 1, hi_us, phase_tag);
				errors++;
			end else begin
				check_motor($sformatf("motor_%0d_rate", m + 1),
					flight_pkg::motor_rate_t'((hi_us - ESC_MIN_US) / ESC_STEP_US),
					flight_pkg::motor_rate_t'(vec[f][11 + m]));
			end
		end
	endtask

	initial begin
		int gap;
		int err_before;
		throttle_pwm = 1'b0;
		roll_pwm = 1'b0;
		pitch_pwm = 1'b0;
		yaw_pwm = 1'b0;
		arm_pwm = 1'b0;
		imu_valid = 1'b0;
		roll_angle = '0;
		pitch_angle = '0;
		roll_gyro = '0;
		pitch_gyro = '0;
		yaw_gyro = '0;
		num_frames = 0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		phase_tag = "setup";
		gap = $urandom(36);
		load_vectors();
		wait_reset_release();
		if (!timed_out) begin
			err_before = errors;
			check_idle_after_reset();
			if (errors == err_before)
				$display("Reset check: ok");
			else
				$display("Reset check: %0d errors", errors - err_before);
		end
		for (int f = 0; f < num_frames && !timed_out; f++) begin
			err_before = errors;
			phase_tag = $sformatf("frame %0d", f);
			drive_sticks(f);
			// Random idle gap, long enough for the decoders to settle
			gap = 8 + int'($urandom % 24);
			repeat (gap) @(posedge sys_clk);
			if (!timed_out)
				run_frame(f, (f % 3) == 1);
			if (!timed_out)
				measure_motors(f);
			if (errors == err_before)
				$display("Frame %0d: ok", f);
			else
				$display("Frame %0d: %0d errors", f, errors - err_before);
		end
		$display("Frames %0d, checks %0d, errors %0d", num_frames, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/flight_vectors.txt ====
# thr roll pitch yaw arm pulse widths (us) | roll_angle pitch_angle roll_gyro pitch_gyro yaw_gyro
# | expected armed | expected motor 1 to 4 rates
1500 1512 1512 1512 1100 0 0 0 0 0 0 0 0 0 0
1500 1512 1512 1512 1900 0 0 0 0 0 1 125 125 125 125
2020 1512 1512 1512 1900 0 0 0 0 0 1 250 250 250 250
2000 1512 1512 1512 1900 0 0 0 0 0 1 250 250 250 250
1500 1640 1512 1512 1900 0 0 0 0 0 1 133 117 117 133
1500 1512 1384 1512 1900 0 0 0 0 0 1 117 117 133 133
1500 1512 1512 1600 1900 0 0 0 0 0 1 114 136 114 136
1500 1512 1512 1512 1900 100 0 30 0 0 1 115 135 135 115
1700 1450 1560 1530 1900 -20 10 -5 40 -7 1 167 177 179 177
1300 1512 1512 1512 1900 45 0 0 0 0 1 72 78 78 72
900 1640 1512 1512 1900 0 0 0 0 0 1 8 0 0 8
1500 1512 1512 1512 1900 0 0 20000 -20000 0 1 124 250 126 0
2500 2100 800 2100 1900 -32768 32767 -32768 32767 0 1 191 0 193 250
1500 1512 1512 1512 1768 0 0 0 0 0 0 0 0 0 0
1500 1512 1512 1512 1772 0 0 0 0 0 1 125 125 125 125
1800 1400 1700 1300 1900 -50 60 25 -16 -12 1 228 192 222 158
1960 1640 1512 1600 1900 0 0 0 0 0 1 237 243 221 250
1500 1512 1512 1512 1100 0 0 0 0 0 0 0 0 0 0

// ==== vlog.f ====
hdl/flight_pkg.sv
hdl/flight_sequencer.sv
hdl/rc_pulse_decoder.sv
hdl/angle_controller.sv
hdl/rate_controller.sv
hdl/motor_mixer.sv
hdl/esc_pwm.sv
hdl/drone_ctrl.sv
testbench/tb_clock.sv
testbench/tb_drone_ctrl.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_drone_ctrl -Mdir obj_dir -f vlog.f

out="$(./obj_dir/Vtb_drone_ctrl)"
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
